// File: common/auMixPkg.sv
package auMixPkg;

	typedef logic [15:0]  cellIxT;     // sample cell index
	typedef logic [127:0] cellDataT;   // one sample cell
	typedef logic [31:0]  ringAddrT;   // ring byte address
	typedef logic [6:0]   bankIxT;     // line in one bank, cell ix bits 7:1
	typedef logic [7:0]   cellTagT;    // cell ix bits 15:8
	typedef logic [7:0]   nodeIdT;

	localparam logic [7:0] opmIdle     = 8'h00;
	localparam logic [7:0] opmLoadReq  = 8'h31;
	localparam logic [7:0] opmLoadResp = 8'h70;   // response class, load ok

	localparam nodeIdT   ownNodeId = 8'h2A;
	localparam ringAddrT cellBase  = 32'h0200_0000;   // 1 MiB aligned sample region
	localparam int       bankLines = 128;

	typedef struct packed
	{
		logic [7:0] opm;
		nodeIdT     srcNode;
		logic [7:0] seqTag;    // bit 7 bank select, 6:0 rover
		ringAddrT   addr;
		cellDataT   data;
	} ringFlitT;

	localparam ringFlitT idleFlit = '{
		opm:     opmIdle,
		srcNode: 8'h00,
		seqTag:  8'h00,
		addr:    32'h0,
		data:    128'h0
	};

	typedef struct packed
	{
		logic   valid;
		cellIxT ix;
	} cellReqT;

	typedef struct packed
	{
		logic     valid;
		cellDataT data;
	} cellRespT;

	typedef struct packed
	{
		logic   valid;
		logic   bank;      // 0 even, 1 odd
		cellIxT ix;
	} missReqT;

	typedef struct packed
	{
		logic     valid;
		cellIxT   ix;
		cellDataT data;
	} fillT;

	// byte address of a cell on the ring
	function automatic ringAddrT cellAddr(cellIxT ix);
		return cellBase + {12'h000, ix, 4'h0};
	endfunction

	// inverse of cellAddr for addresses inside the sample region
	function automatic cellIxT cellIxOf(ringAddrT addr);
		ringAddrT offset;
		offset = addr - cellBase;
		return offset[19:4];
	endfunction

endpackage

// File: cache/cellCacheBank.sv
module cellCacheBank
(
	input  logic               clock,
	input  logic               reset,
	input  auMixPkg::cellIxT   lookupIx,
	input  auMixPkg::fillT     fill,
	output logic               hit,
	output auMixPkg::cellDataT hitData
);

	logic [auMixPkg::bankLines-1:0] lineValid;
	auMixPkg::cellTagT  tagArr  [auMixPkg::bankLines];
	auMixPkg::cellDataT dataArr [auMixPkg::bankLines];

	auMixPkg::bankIxT   rdLine;
	auMixPkg::bankIxT   fillLine;
	auMixPkg::cellTagT  lookupTag;
	auMixPkg::cellTagT  lookupTagL;   // tag of the lookup now being answered
	auMixPkg::cellTagT  fillTag;
	auMixPkg::cellTagT  rdTag;
	auMixPkg::cellDataT rdData;
	logic               rdValid;

	assign rdLine    = lookupIx[7:1];
	assign lookupTag = lookupIx[15:8];
	assign fillLine  = fill.ix[7:1];
	assign fillTag   = fill.ix[15:8];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lineValid <= '0;
			rdValid   <= 1'b0;
		end
		else
		begin
			rdValid <= lineValid[rdLine];   // old value on a same-cycle fill
			if (fill.valid)
				lineValid[fillLine] <= 1'b1;
		end
	end

	// tag and data arrays, read registered
	always_ff @(posedge clock)
	begin
		rdTag      <= tagArr[rdLine];
		rdData     <= dataArr[rdLine];
		lookupTagL <= lookupTag;
		if (fill.valid)
		begin
			tagArr[fillLine]  <= fillTag;
			dataArr[fillLine] <= fill.data;
		end
	end

	assign hit     = rdValid && (rdTag == lookupTagL);
	assign hitData = rdData;

endmodule

// File: rtl/cellMerge.sv
module cellMerge
(
	input  logic               clock,
	input  logic               reset,
	input  auMixPkg::cellReqT  cellReq,
	output logic               cellReqReady,
	output auMixPkg::cellRespT cellResp,
	input  logic               cellRespReady,
	output auMixPkg::cellIxT   evenIx,
	output auMixPkg::cellIxT   oddIx,
	input  logic               evenHit,
	input  logic               oddHit,
	input  auMixPkg::cellDataT evenData,
	input  auMixPkg::cellDataT oddData,
	output auMixPkg::missReqT  missReq,
	input  logic               missReady
);

	typedef enum logic [2:0] {idle, lookup, fetch, waitFill, respond} stateT;

	stateT              state;
	stateT              stateNext;
	auMixPkg::cellIxT   reqIx;
	auMixPkg::cellIxT   nextIx;
	auMixPkg::cellIxT   curIx;
	auMixPkg::cellIxT   curNextIx;
	auMixPkg::cellIxT   pfWantIx;   // prefetch waiting for a ring slot
	auMixPkg::cellIxT   pfIx [2];   // prefetch in flight, per bank
	logic [1:0]         pfPend;
	logic               pfWant;
	logic               pfGo;
	logic               pfMatch;
	logic               pfNeed;
	logic               reqBank;
	logic               nextBank;
	logic               reqHit;
	logic               nextHit;
	logic               lookValid;
	auMixPkg::cellDataT reqData;
	auMixPkg::cellDataT respData;

	// idle looks up the incoming index so a hit costs only two cycles
	assign curIx     = (state == idle) ? cellReq.ix : reqIx;
	assign curNextIx = curIx + 16'd1;
	assign evenIx    = curIx[0] ? curNextIx : curIx;
	assign oddIx     = curIx[0] ? curIx : curNextIx;

	assign reqBank   = reqIx[0];
	assign nextBank  = ~reqIx[0];
	assign nextIx    = reqIx + 16'd1;
	assign reqHit    = reqBank ? oddHit : evenHit;
	assign nextHit   = reqBank ? evenHit : oddHit;
	assign reqData   = reqBank ? oddData : evenData;
	assign lookValid = (state == lookup) || (state == waitFill);

	assign pfMatch = pfPend[reqBank] && (pfIx[reqBank] == reqIx);   // already on its way
	assign pfNeed  = !nextHit && !(pfPend[nextBank] && (pfIx[nextBank] == nextIx));
	assign pfGo    = missReady && (state != fetch);

	always_comb
	begin
		stateNext = state;
		unique case (state)
			idle:     if (cellReq.valid) stateNext = lookup;
			lookup:   stateNext = reqHit ? respond : (pfMatch ? waitFill : fetch);
			fetch:    if (missReady) stateNext = waitFill;
			waitFill: if (reqHit) stateNext = respond;
			respond:  if (cellRespReady) stateNext = idle;
			default:  stateNext = idle;
		endcase
	end

	// demand load first, prefetch whenever no demand is being sent
	always_comb
	begin
		missReq = '0;
		if (state == fetch)
			missReq = '{valid: 1'b1, bank: reqBank, ix: reqIx};
		else if (pfWant && (state != lookup))
			missReq = '{valid: 1'b1, bank: pfWantIx[0], ix: pfWantIx};
	end

	assign cellReqReady = (state == idle);
	assign cellResp     = '{valid: (state == respond), data: respData};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state  <= idle;
			pfWant <= 1'b0;
			pfPend <= 2'b00;
		end
		else
		begin
			state <= stateNext;
			if (lookValid && reqHit && (pfIx[reqBank] == reqIx))
				pfPend[reqBank] <= 1'b0;    // prefetched cell has landed
			if (lookValid && nextHit && (pfIx[nextBank] == nextIx))
				pfPend[nextBank] <= 1'b0;
			if ((state == fetch) && missReady)
				pfPend[reqBank] <= 1'b0;    // a newer load owns this bank
			if ((state == lookup) && pfWant && (pfWantIx == reqIx))
				pfWant <= 1'b0;             // turned into a demand
			if ((state == lookup) && !reqHit && pfNeed)
				pfWant <= 1'b1;
			if (pfGo)
			begin
				pfWant              <= 1'b0;
				pfPend[pfWantIx[0]] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if ((state == idle) && cellReq.valid)
			reqIx <= cellReq.ix;
		if (lookValid && reqHit)
			respData <= reqData;
		if ((state == lookup) && !reqHit && pfNeed)
			pfWantIx <= nextIx;
		if (pfGo)
			pfIx[pfWantIx[0]] <= pfWantIx;
	end

endmodule

// File: ringbus/ringNode.sv
module ringNode
(
	input  logic               clock,
	input  logic               reset,
	input  auMixPkg::ringFlitT ringIn,
	output auMixPkg::ringFlitT ringOut,
	input  auMixPkg::missReqT  missReq,
	output logic               missReady,
	output auMixPkg::fillT     fillEven,
	output auMixPkg::fillT     fillOdd
);

	logic               slotIdle;
	logic               ownResp;
	logic               slotFree;
	logic [6:0]         rover;       // sequence count for our requests
	auMixPkg::ringFlitT reqFlit;
	auMixPkg::cellIxT   respIx;
	auMixPkg::cellIxT   fillIxL;
	auMixPkg::cellDataT fillDataL;
	logic               fillEvenV;
	logic               fillOddV;

	assign slotIdle = (ringIn.opm == auMixPkg::opmIdle);
	assign ownResp  = (ringIn.opm == auMixPkg::opmLoadResp) &&
		(ringIn.srcNode == auMixPkg::ownNodeId);
	assign slotFree = slotIdle || ownResp;   // our own responses free their slot

	// request goes out this cycle only into a free slot
	assign missReady = slotFree && missReq.valid;

	assign reqFlit = '{
		opm:     auMixPkg::opmLoadReq,
		srcNode: auMixPkg::ownNodeId,
		seqTag:  {missReq.bank, rover},
		addr:    auMixPkg::cellAddr(missReq.ix),
		data:    '0
	};

	assign respIx = auMixPkg::cellIxOf(ringIn.addr);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ringOut <= auMixPkg::idleFlit;
			rover   <= 7'd0;
		end
		else if (slotFree)
		begin
			ringOut <= missReq.valid ? reqFlit : auMixPkg::idleFlit;
			if (missReq.valid)
				rover <= rover + 7'd1;
		end
		else
			ringOut <= ringIn;   // foreign flit, one stage
	end

	// bank chosen by the tag bit stamped at insertion
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fillEvenV <= 1'b0;
			fillOddV  <= 1'b0;
		end
		else
		begin
			fillEvenV <= ownResp && !ringIn.seqTag[7];
			fillOddV  <= ownResp && ringIn.seqTag[7];
		end
	end

	always_ff @(posedge clock)
	begin
		fillIxL   <= respIx;
		fillDataL <= ringIn.data;
	end

	assign fillEven = '{valid: fillEvenV, ix: fillIxL, data: fillDataL};
	assign fillOdd  = '{valid: fillOddV, ix: fillIxL, data: fillDataL};

endmodule

// File: rtl/auMixFetch.sv
module auMixFetch
(
	input  logic               clock,
	input  logic               reset,
	input  auMixPkg::cellReqT  cellReq,
	output logic               cellReqReady,
	output auMixPkg::cellRespT cellResp,
	input  logic               cellRespReady,
	input  auMixPkg::ringFlitT ringIn,
	output auMixPkg::ringFlitT ringOut
);

	auMixPkg::cellIxT   evenIx;
	auMixPkg::cellIxT   oddIx;
	logic               evenHit;
	logic               oddHit;
	auMixPkg::cellDataT evenData;
	auMixPkg::cellDataT oddData;
	auMixPkg::missReqT  missReq;
	logic               missReady;
	auMixPkg::fillT     fillEven;
	auMixPkg::fillT     fillOdd;

	cellCacheBank evenBank   // even cell indices
	(
		.clock    (clock),
		.reset    (reset),
		.lookupIx (evenIx),
		.fill     (fillEven),
		.hit      (evenHit),
		.hitData  (evenData)
	);

	cellCacheBank oddBank    // odd cell indices
	(
		.clock    (clock),
		.reset    (reset),
		.lookupIx (oddIx),
		.fill     (fillOdd),
		.hit      (oddHit),
		.hitData  (oddData)
	);

	cellMerge merge
	(
		.clock         (clock),
		.reset         (reset),
		.cellReq       (cellReq),
		.cellReqReady  (cellReqReady),
		.cellResp      (cellResp),
		.cellRespReady (cellRespReady),
		.evenIx        (evenIx),
		.oddIx         (oddIx),
		.evenHit       (evenHit),
		.oddHit        (oddHit),
		.evenData      (evenData),
		.oddData       (oddData),
		.missReq       (missReq),
		.missReady     (missReady)
	);

	ringNode node
	(
		.clock     (clock),
		.reset     (reset),
		.ringIn    (ringIn),
		.ringOut   (ringOut),
		.missReq   (missReq),
		.missReady (missReady),
		.fillEven  (fillEven),
		.fillOdd   (fillOdd)
	);

endmodule

// File: dv/auMixFetch_assert.sv
module auMixFetchAssert
(
	input logic               clock,
	input logic               reset,
	input logic               cellReqReady,
	input auMixPkg::cellRespT cellResp,
	input logic               cellRespReady,
	input auMixPkg::ringFlitT ringOut
);

	timeunit 1ns;
	timeprecision 1ps;

	// a refused response holds until taken
	respHeld: assert property (@(posedge clock) disable iff (reset)
		cellResp.valid && !cellRespReady |=> cellResp.valid && $stable(cellResp.data))
		else $error("cellResp changed while waiting for ready");

	noOwnResp: assert property (@(posedge clock) disable iff (reset)
		!((ringOut.opm == auMixPkg::opmLoadResp) && (ringOut.srcNode == auMixPkg::ownNodeId)))
		else $error("own load response passed on to ringOut");

	reqBlocked: assert property (@(posedge clock) disable iff (reset)
		cellResp.valid |-> !cellReqReady)
		else $error("cellReqReady high while a response waits");

endmodule

bind auMixFetch auMixFetchAssert assertInst
(
	.clock         (clock),
	.reset         (reset),
	.cellReqReady  (cellReqReady),
	.cellResp      (cellResp),
	.cellRespReady (cellRespReady),
	.ringOut       (ringOut)
);

// File: dv/auMixFetchTb.sv
module auMixFetchTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int waitLimit = 600;   // cycles per wait

	logic               clock;
	logic               reset = 1'b1;
	auMixPkg::cellReqT  cellReq = '0;
	logic               cellReqReady;
	auMixPkg::cellRespT cellResp;
	logic               cellRespReady = 1'b0;
	auMixPkg::ringFlitT ringIn = auMixPkg::idleFlit;
	auMixPkg::ringFlitT ringOut;

	int    mainErrors = 0;
	int    compErrors = 0;
	int    reqCount = 0;
	int    respCount = 0;
	logic  hung = 1'b0;
	int    foreignPct = 20;   // share of slots with other nodes' traffic
	logic  stallMode = 1'b0;
	logic  hitCheck = 1'b0;
	string testName = "reset";
	int    loadCount [logic [31:0]];   // own load requests per address

	auMixPkg::ringFlitT pendFlit [$];   // responses not yet sent
	int                 pendDue [$];
	int                 ringTick = 0;

	auMixPkg::ringFlitT fwdFlit;
	logic               fwdValid = 1'b0;
	logic               holdValid = 1'b0;
	logic [127:0]       holdData;
	logic               accOpen = 1'b0;
	logic               accLat;
	logic [15:0]        accIx;
	string              accName;
	int                 accTick;
	logic               seen = 1'b0;
	int                 seenTick;
	int                 compTick = 0;

	auMixFetch auMixFetch_inst
	(
		.clock         (clock),
		.reset         (reset),
		.cellReq       (cellReq),
		.cellReqReady  (cellReqReady),
		.cellResp      (cellResp),
		.cellRespReady (cellRespReady),
		.ringIn        (ringIn),
		.ringOut       (ringOut)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] addrOf(logic [15:0] ix);
		return auMixPkg::cellBase + 32'(ix) * 32'd16;   // 16 bytes per cell
	endfunction

	// expected cell contents, built from the whole address
	function automatic logic [127:0] cellPattern(logic [31:0] addr);
		return {addr ^ 32'h5A0F_C3E1, ~addr, {addr[15:0], addr[31:16]}, addr * 32'h9E37_79B1};
	endfunction

	function automatic int loadsOf(logic [31:0] addr);
		if (loadCount.exists(addr))
			return loadCount[addr];
		return 0;
	endfunction

	function automatic auMixPkg::ringFlitT foreignFlit();
		auMixPkg::ringFlitT f;
		f.opm     = ($urandom % 2 == 0) ? auMixPkg::opmLoadReq : auMixPkg::opmLoadResp;
		f.srcNode = 8'($urandom);
		if (f.srcNode == auMixPkg::ownNodeId)
			f.srcNode = f.srcNode ^ 8'h01;   // never our own id
		f.seqTag  = 8'($urandom);
		f.addr    = $urandom;
		f.data    = {$urandom, $urandom, $urandom, $urandom};
		return f;
	endfunction

	task automatic expectEqual(input string name, input logic [255:0] expected,
		input logic [255:0] actual, inout int count);
		if (expected !== actual)
		begin
			count++;
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// one request through the valid/ready handshake, then its response
	task automatic fetchCell(input logic [15:0] ix);
		int   waited;
		logic done;
		if (hung)
			return;
		cellReq <= '{valid: 1'b1, ix: ix};
		reqCount++;
		waited = 0;
		done   = 1'b0;
		while (!done && waited < waitLimit)
		begin
			@(posedge clock);
			done = cellReqReady;
			waited++;
		end
		cellReq <= '0;
		if (!done)
		begin
			$display("timeout: request for cell %h was never accepted", ix);
			mainErrors++;
			hung = 1'b1;
			return;
		end
		waited = 0;
		done   = 1'b0;
		while (!done && waited < waitLimit)
		begin
			@(posedge clock);
			done = cellResp.valid && cellRespReady;
			waited++;
		end
		if (!done)
		begin
			$display("timeout: no response for cell %h", ix);
			mainErrors++;
			hung = 1'b1;
		end
	endtask

	always @(posedge clock)
	begin
		if (stallMode)
			cellRespReady <= ($urandom % 4) == 0;   // mostly busy
		else
			cellRespReady <= 1'b1;
	end

	// memory behind the ring plus other nodes' traffic
	always @(posedge clock)
	begin
		auMixPkg::ringFlitT resp;
		int                 pick;
		if (reset)
			ringIn <= auMixPkg::idleFlit;
		else
		begin
			if (ringOut.opm == auMixPkg::opmLoadReq && ringOut.srcNode == auMixPkg::ownNodeId)
			begin
				loadCount[ringOut.addr] = loadsOf(ringOut.addr) + 1;
				resp      = ringOut;
				resp.opm  = auMixPkg::opmLoadResp;
				resp.data = cellPattern(ringOut.addr);
				pendFlit.push_back(resp);
				pendDue.push_back(ringTick + 3 + int'($urandom % 18));   // 3 to 20 cycles
			end
			pick = -1;
			foreach (pendDue[i])
				if (pick < 0 && pendDue[i] <= ringTick)
					pick = i;
			if (pick >= 0)
			begin
				ringIn <= pendFlit[pick];
				pendFlit.delete(pick);
				pendDue.delete(pick);
			end
			else if (int'($urandom % 100) < foreignPct)
				ringIn <= foreignFlit();
			else
				ringIn <= auMixPkg::idleFlit;
			ringTick++;
		end
	end

	// compare process
	always @(posedge clock)
	begin
		if (reset)
			fwdValid = 1'b0;
		else
		begin
			if (fwdValid)
				expectEqual("forward", 256'(fwdFlit), 256'(ringOut), compErrors);
			expectEqual("own response on ringOut", 256'(0),
				256'(ringOut.opm == auMixPkg::opmLoadResp &&
				ringOut.srcNode == auMixPkg::ownNodeId), compErrors);
			fwdFlit  = ringIn;
			fwdValid = (ringIn.opm != auMixPkg::opmIdle) &&
				!(ringIn.opm == auMixPkg::opmLoadResp && ringIn.srcNode == auMixPkg::ownNodeId);
			if (holdValid)
				expectEqual("held response", 256'({1'b1, holdData}), 256'(cellResp), compErrors);
			holdValid = cellResp.valid && !cellRespReady;
			holdData  = cellResp.data;
			if (cellResp.valid)
				expectEqual("ready while response waits", 256'(0), 256'(cellReqReady),
					compErrors);
			if (cellReq.valid && cellReqReady)
			begin
				accOpen = 1'b1;
				accIx   = cellReq.ix;
				accName = testName;
				accLat  = hitCheck;
				accTick = compTick;
				seen    = 1'b0;
			end
			if (cellResp.valid && !seen)
			begin
				seen     = 1'b1;
				seenTick = compTick;
			end
			if (cellResp.valid && cellRespReady)
			begin
				if (!accOpen)
				begin
					$display("response delivered without an accepted request");
					compErrors++;
				end
				else
				begin
					expectEqual(accName, 256'(cellPattern(addrOf(accIx))),
						256'(cellResp.data), compErrors);
					if (accLat)
						expectEqual({accName, " latency"}, 256'(2),
							256'(seenTick - accTick), compErrors);
				end
				accOpen = 1'b0;
				seen    = 1'b0;
				respCount++;
			end
			compTick++;
		end
	end

	initial
	begin
		logic [15:0] ix0;
		logic [15:0] ix1;
		logic [15:0] conflictA;
		logic [15:0] conflictB;
		void'($urandom(58214));
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);

		testName = "miss then fetch";
		ix0 = 16'($urandom) & 16'hFFFE;   // even cell
		fetchCell(ix0);
		expectEqual("miss load count", 256'(1), 256'(loadsOf(addrOf(ix0))), mainErrors);
		expectEqual("prefetch even issued", 256'(1), 256'(loadsOf(addrOf(ix0 + 16'd1))),
			mainErrors);

		testName = "repeat hit";
		hitCheck = 1'b1;
		fetchCell(ix0);
		hitCheck = 1'b0;
		expectEqual("hit load count", 256'(1), 256'(loadsOf(addrOf(ix0))), mainErrors);

		testName = "prefetch even";
		fetchCell(ix0 + 16'd1);
		expectEqual("prefetch even loads", 256'(1), 256'(loadsOf(addrOf(ix0 + 16'd1))),
			mainErrors);

		testName = "prefetch odd";
		ix1 = ix0 + 16'h0021;   // odd cell on other lines
		fetchCell(ix1);
		expectEqual("prefetch odd issued", 256'(1), 256'(loadsOf(addrOf(ix1 + 16'd1))),
			mainErrors);
		fetchCell(ix1 + 16'd1);
		expectEqual("prefetch odd loads", 256'(1), 256'(loadsOf(addrOf(ix1 + 16'd1))),
			mainErrors);

		testName   = "heavy traffic";
		foreignPct = 90;
		repeat (6) fetchCell(16'($urandom));
		foreignPct = 20;

		testName  = "back-pressure";
		stallMode = 1'b1;
		repeat (12) fetchCell(ix0 + 16'($urandom % 6));
		stallMode = 1'b0;

		testName  = "conflict eviction";
		conflictA = 16'($urandom);
		conflictB = conflictA ^ 16'h0100;   // same line, other tag
		repeat (2)
		begin
			fetchCell(conflictA);
			fetchCell(conflictB);
		end

		@(posedge clock);
		expectEqual("response count", 256'(reqCount), 256'(respCount), mainErrors);
		$display("errors %0d (driver %0d, compare %0d), responses %0d",
			mainErrors + compErrors, mainErrors, compErrors, respCount);
		if (mainErrors + compErrors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: tb.f
common/auMixPkg.sv
cache/cellCacheBank.sv
rtl/cellMerge.sv
ringbus/ringNode.sv
rtl/auMixFetch.sv
dv/auMixFetch_assert.sv
dv/auMixFetchTb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= auMixFetchTb
FILELIST    ?= tb.f
OBJ_DIR     ?= obj_dir
TIMESCALE   ?= 1ns/1ps
VFLAGS      ?= --binary --timing --assert
ERROR_LIMIT ?= 1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# simulation output is searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
